/* hw/mem_pkg.sv */
package mem_pkg;

    // ------------------------------------------------------------
    // Memory port widths
    // ------------------------------------------------------------
    localparam int MEM_ADDR_W = 25;             // Byte address into the SDRAM
    localparam int MEM_DATA_W = 32;             // One word per access
    localparam int MEM_MASK_W = MEM_DATA_W / 8; // One enable per byte lane

    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [MEM_DATA_W-1:0] mem_data_t;
    typedef logic [MEM_MASK_W-1:0] mem_mask_t;  // Any set bit makes a write

    // Full word write
    localparam mem_mask_t WMASK_ALL = '1;

    // ------------------------------------------------------------
    // Request bundle toward the controller
    // ------------------------------------------------------------
    // valid is a one-cycle strobe per request.
    // The other fields are held by the requester until done comes back.
    typedef struct packed {
        logic      valid;   // Start of request
        logic      rstrb;   // Read when high
        mem_addr_t addr;
        mem_data_t wdata;   // Only meaningful on writes
        mem_mask_t wmask;   // Nonzero for writes
    } mem_req_t;            // 63 bits

endpackage

/* hw/soc_pkg.sv */
package soc_pkg;

    // ------------------------------------------------------------
    // Sequencer FSM
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        CTRL_RESET,     // Controller held in reset
        CTRL_RESETTING, // Second reset cycle
        WAIT_INIT,      // Waiting for controller init done
        ISSUE,          // Start strobe for current script step
        WAIT_DONE,      // Request outstanding
        SHOW,           // Word on display, user stepping bytes
        NEXT,           // Advance script index
        IDLE            // Script finished
    } soc_state_t;

    // ------------------------------------------------------------
    // Script
    // ------------------------------------------------------------
    typedef struct packed {
        logic               is_write;   // Else a read
        mem_pkg::mem_addr_t addr;
        mem_pkg::mem_data_t wdata;      // Write data, unused on reads
    } script_op_t;

    localparam int SCRIPT_LEN = 4;      // Read 0, read 4, write 8, read 8

    typedef logic [1:0] script_idx_t;

    // ------------------------------------------------------------
    // Display
    // ------------------------------------------------------------
    typedef logic [1:0] byte_sel_t;     // 3 is the MSB
    typedef logic [7:0] port_byte_t;

    localparam byte_sel_t  BYTE_TOP     = 2'd3;
    localparam port_byte_t IDLE_PATTERN = 8'h81;   // Outer two LEDs lit

endpackage

/* hw/step_button.sv */
`timescale 1ns/1ps

module step_button #(
    parameter int SYNC_STAGES = 2
) (
    input  logic sdram_clk,
    input  logic rst_n,
    input  logic button,    // Active low, asynchronous
    output logic step       // One pulse per press
);

    logic [SYNC_STAGES-1:0] sync_q;
    logic                   btn_low;    // Synchronized press
    logic                   lock;       // Press already counted

    // Synchronizer chain, resets to the released level
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            sync_q <= '1;
        end else begin
            sync_q[0] <= button;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign btn_low = ~sync_q[SYNC_STAGES-1];

    // Step on first low sample, then lock until release
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            step <= 1'b0;
            lock <= 1'b0;
        end else begin
            step <= btn_low & ~lock;
            if (!btn_low) begin
                lock <= 1'b0;   // Released, arm for next press
            end else if (!lock) begin
                lock <= 1'b1;
            end
        end
    end

    // Held button must not repeat steps
    a_step_single: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        step |=> !step)
        else $error("step_button: step high two cycles in a row");

endmodule

/* hw/mem_access.sv */
`timescale 1ns/1ps

module mem_access (
    input  logic                sdram_clk,
    input  logic                rst_n,
    input  logic                start,      // From sequencer ISSUE
    input  soc_pkg::script_op_t op,
    output mem_pkg::mem_req_t   mem_req,
    input  logic                mem_done,   // One-cycle pulse from controller
    input  mem_pkg::mem_data_t  mem_rdata,  // Valid with mem_done
    output logic                op_done,
    output mem_pkg::mem_data_t  word        // Last word read
);
    import mem_pkg::*;

    logic      req_valid;
    logic      req_rstrb;
    mem_mask_t req_wmask;
    mem_addr_t req_addr;
    mem_data_t req_wdata;
    logic      busy;        // Request outstanding

    // ------------------------------------------------------------
    // Strobe and request kind
    // ------------------------------------------------------------
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            req_valid <= 1'b0;
            req_rstrb <= 1'b0;
            req_wmask <= '0;
            busy      <= 1'b0;
            op_done   <= 1'b0;
        end else begin
            req_valid <= start;                 // One cycle after start
            op_done   <= busy & mem_done;       // One cycle after done
            if (start) begin
                busy      <= 1'b1;
                req_rstrb <= ~op.is_write;
                req_wmask <= op.is_write ? WMASK_ALL : '0;
            end else if (busy && mem_done) begin
                busy      <= 1'b0;
                req_rstrb <= 1'b0;              // Drop activity indication
                req_wmask <= '0;
            end
        end
    end

    // Address, data and read word
    always_ff @(posedge sdram_clk) begin
        if (start) begin
            req_addr  <= op.addr;
            req_wdata <= op.wdata;
        end
        if (busy && mem_done && req_rstrb) begin
            word <= mem_rdata;                  // Capture on the done cycle
        end
    end

    assign mem_req = '{valid: req_valid, rstrb: req_rstrb, addr: req_addr,
                       wdata: req_wdata, wmask: req_wmask};

    a_valid_pulse: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        mem_req.valid |=> !mem_req.valid)
        else $error("mem_access: valid longer than one cycle");

    // Sequencer must wait for op_done before the next step
    a_no_start_busy: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        busy |-> !start)
        else $error("mem_access: start while request outstanding");

endmodule

/* hw/byte_display.sv */
`timescale 1ns/1ps

module byte_display (
    input  logic                sdram_clk,
    input  logic                rst_n,
    input  logic                load,       // New word from a read
    input  mem_pkg::mem_data_t  word,
    input  logic                step,       // Button step
    input  logic                idle,       // Script done
    output soc_pkg::port_byte_t port_a,
    output logic                word_shown  // Step past the last byte
);
    import mem_pkg::*;
    import soc_pkg::*;

    mem_data_t word_q;  // Word being shown
    byte_sel_t sel;     // Byte on port_a

    function automatic port_byte_t pick_byte(mem_data_t w, byte_sel_t s);
        return w[8*int'(s) +: 8];
    endfunction

    always_ff @(posedge sdram_clk) begin
        if (load) begin
            word_q <= word;
        end
    end

    // ------------------------------------------------------------
    // Byte walk from the MSB down
    // ------------------------------------------------------------
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            sel    <= '0;
            port_a <= '0;
        end else if (idle) begin
            port_a <= IDLE_PATTERN;     // Steps ignored here
        end else if (load) begin
            sel    <= BYTE_TOP;
            port_a <= pick_byte(word, BYTE_TOP);
        end else if (step && sel != '0) begin
            sel    <= sel - byte_sel_t'(1);
            port_a <= pick_byte(word_q, sel - byte_sel_t'(1));
        end
    end

    // Step on byte 0 keeps port_a and releases the sequencer
    assign word_shown = step && (sel == '0) && !idle;

    // Read completion and a button step must not collide
    a_load_step: assert property (@(posedge sdram_clk) disable iff (!rst_n)
        !(load && step))
        else $error("byte_display: load and step in the same cycle");

endmodule

/* hw/soc_sequencer.sv */
`timescale 1ns/1ps

module soc_sequencer #(
    parameter mem_pkg::mem_data_t WRITE_WORD = 32'h1234_5678
) (
    input  logic                sdram_clk,
    input  logic                rst_n,
    input  logic                mem_init,       // Controller init finished
    output logic                ctrl_rst_n,     // Active-low controller reset
    output logic                start,          // Launch current step
    output soc_pkg::script_op_t op,
    input  logic                op_done,
    output logic                is_read_done,   // Load for the display
    input  logic                word_shown,
    output logic                idle
);
    import mem_pkg::*;
    import soc_pkg::*;

    // ------------------------------------------------------------
    // Script table
    // ------------------------------------------------------------
    localparam script_op_t SCRIPT [SCRIPT_LEN] = '{
        '{is_write: 1'b0, addr: mem_addr_t'(0), wdata: '0},            // Read 0
        '{is_write: 1'b0, addr: mem_addr_t'(4), wdata: '0},            // Read 4
        '{is_write: 1'b1, addr: mem_addr_t'(8), wdata: WRITE_WORD},    // Write 8
        '{is_write: 1'b0, addr: mem_addr_t'(8), wdata: '0}             // Read back 8
    };

    localparam script_idx_t LAST_IDX = script_idx_t'(SCRIPT_LEN - 1);

    soc_state_t  state;
    soc_state_t  state_nxt;
    script_idx_t idx;       // Current step
    script_idx_t idx_nxt;

    assign op = SCRIPT[idx];    // Stable through ISSUE and WAIT_DONE

    // ------------------------------------------------------------
    // State registers
    // ------------------------------------------------------------
    always_ff @(posedge sdram_clk) begin
        if (!rst_n) begin
            state <= CTRL_RESET;
            idx   <= '0;
        end else begin
            state <= state_nxt;
            idx   <= idx_nxt;
        end
    end

    // ------------------------------------------------------------
    // Next state
    // ------------------------------------------------------------
    always_comb begin
        state_nxt    = state;
        idx_nxt      = idx;
        start        = 1'b0;
        is_read_done = 1'b0;

        case (state)
            CTRL_RESET: begin
                state_nxt = CTRL_RESETTING;
            end

            CTRL_RESETTING: begin
                state_nxt = WAIT_INIT;          // Two cycles of controller reset
            end

            WAIT_INIT: begin
                if (mem_init) begin
                    state_nxt = ISSUE;
                end
            end

            ISSUE: begin
                start     = 1'b1;               // Single cycle
                state_nxt = WAIT_DONE;
            end

            WAIT_DONE: begin
                if (op_done) begin
                    if (op.is_write) begin
                        state_nxt = NEXT;       // Nothing to show
                    end else begin
                        is_read_done = 1'b1;
                        state_nxt    = SHOW;
                    end
                end
            end

            SHOW: begin
                // Display walks the bytes on its own
                if (word_shown) begin
                    state_nxt = NEXT;
                end
            end

            NEXT: begin
                if (idx == LAST_IDX) begin
                    state_nxt = IDLE;
                end else begin
                    idx_nxt   = idx + script_idx_t'(1);
                    state_nxt = ISSUE;
                end
            end

            IDLE: begin
                state_nxt = IDLE;               // Stays until reset
            end

            default: begin
                state_nxt = CTRL_RESET;
            end
        endcase
    end

    assign ctrl_rst_n = !(state inside {CTRL_RESET, CTRL_RESETTING});
    assign idle       = (state == IDLE);

endmodule

/* hw/sdram_test_soc.sv */
`timescale 1ns/1ps

module sdram_test_soc #(
    parameter int                 SYNC_STAGES = 2,
    parameter mem_pkg::mem_data_t WRITE_WORD  = 32'h1234_5678
) (
    input  logic                sdram_clk,
    input  logic                rst_n,
    input  logic                button,     // Active low
    output soc_pkg::port_byte_t port_a,

    // ------------------------------------------------------------
    // SDRAM controller side
    // ------------------------------------------------------------
    output logic                ctrl_rst_n,
    input  logic                mem_init,
    output mem_pkg::mem_req_t   mem_req,
    input  logic                mem_done,
    input  mem_pkg::mem_data_t  mem_rdata
);
    import mem_pkg::*;
    import soc_pkg::*;

    logic       step;           // Debounced press
    logic       start;
    script_op_t op;
    logic       op_done;
    mem_data_t  word;           // Last read word
    logic       is_read_done;   // Display load
    logic       word_shown;
    logic       idle;

    step_button #(
        .SYNC_STAGES(SYNC_STAGES)
    ) i_step_button (
        .sdram_clk(sdram_clk),
        .rst_n    (rst_n),
        .button   (button),
        .step     (step)
    );

    soc_sequencer #(
        .WRITE_WORD(WRITE_WORD)
    ) i_soc_sequencer (
        .sdram_clk   (sdram_clk),
        .rst_n       (rst_n),
        .mem_init    (mem_init),
        .ctrl_rst_n  (ctrl_rst_n),
        .start       (start),
        .op          (op),
        .op_done     (op_done),
        .is_read_done(is_read_done),
        .word_shown  (word_shown),
        .idle        (idle)
    );

    mem_access i_mem_access (
        .sdram_clk(sdram_clk),
        .rst_n    (rst_n),
        .start    (start),
        .op       (op),
        .mem_req  (mem_req),
        .mem_done (mem_done),
        .mem_rdata(mem_rdata),
        .op_done  (op_done),
        .word     (word)
    );

    byte_display i_byte_display (
        .sdram_clk (sdram_clk),
        .rst_n     (rst_n),
        .load      (is_read_done),  // Read finished
        .word      (word),
        .step      (step),
        .idle      (idle),
        .port_a    (port_a),
        .word_shown(word_shown)
    );

endmodule

/* bench/sdram_ctrl_model.sv */
`timescale 1ns/1ps

module sdram_ctrl_model #(
    parameter int          LOG_DEPTH  = 8,
    parameter int          INIT_DELAY = 20,             // Cycles from reset release to init
    parameter int unsigned SEED       = 32'hecfc1ddc
) (
    input  logic               sdram_clk,
    input  logic               ctrl_rst_n,
    output logic               mem_init,
    input  mem_pkg::mem_req_t  mem_req,
    output logic               mem_done,
    output mem_pkg::mem_data_t mem_rdata,
    output int                 req_count,               // Requests seen so far
    output mem_pkg::mem_req_t  req_log [LOG_DEPTH],
    output int                 proto_errors
);
    import mem_pkg::*;

    mem_data_t mem [mem_addr_t];    // Only written and preloaded words
    int        init_cnt;

    // Unwritten words read back as a pattern of their address
    function automatic mem_data_t read_word(mem_addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return {7'h55, a};
    endfunction

    // Init done a fixed time after reset release
    always @(posedge sdram_clk) begin
        if (ctrl_rst_n !== 1'b1) begin
            init_cnt <= 0;
        end else if (init_cnt < INIT_DELAY) begin
            init_cnt <= init_cnt + 1;
        end
    end

    assign mem_init = (init_cnt == INIT_DELAY);

    // ------------------------------------------------------------
    // Request service with a single outstanding request
    // ------------------------------------------------------------
    initial begin : serve
        mem_req_t    held;          // Request being served
        logic        busy;
        int unsigned wait_cnt;
        mem_data_t   merged;

        void'($urandom(SEED));
        mem[25'h0]   = 32'h2130_5555;
        mem[25'h4]   = 32'h5159_5451;
        busy         = 1'b0;
        wait_cnt     = 0;
        req_count    = 0;
        proto_errors = 0;
        mem_done    <= 1'b0;
        mem_rdata   <= '0;
        forever begin
            @(posedge sdram_clk);
            if (busy) begin
                if (mem_req.valid) begin
                    $display("Controller model: new request while one is outstanding");
                    proto_errors++;
                end
                if ({mem_req.rstrb, mem_req.addr, mem_req.wdata, mem_req.wmask} !==
                    {held.rstrb, held.addr, held.wdata, held.wmask}) begin
                    $display("Controller model: request fields changed before done");
                    proto_errors++;
                end
                if (mem_done) begin
                    mem_done <= 1'b0;                   // One-cycle pulse
                    busy = 1'b0;
                end else if (wait_cnt == 0) begin
                    mem_done <= 1'b1;
                    if (held.wmask != '0) begin
                        merged = read_word(held.addr);
                        for (int b = 0; b < 4; b++) begin
                            if (held.wmask[b]) begin
                                merged[8*b +: 8] = held.wdata[8*b +: 8];
                            end
                        end
                        mem[held.addr] = merged;
                    end else begin
                        mem_rdata <= read_word(held.addr); // Valid with done
                    end
                end else begin
                    wait_cnt--;
                end
            end else if (mem_req.valid) begin
                if (!mem_init) begin
                    $display("Controller model: request before init finished");
                    proto_errors++;
                end
                if (req_count < LOG_DEPTH) begin
                    req_log[req_count] = mem_req;
                end
                req_count++;
                held     = mem_req;
                busy     = 1'b1;
                wait_cnt = 1 + ($urandom % 8);  // Done 2 to 9 cycles later
            end
        end
    end

endmodule

/* bench/tb_sdram_test_soc.sv */
`timescale 1ns/1ps

module tb_sdram_test_soc;
    import mem_pkg::*;
    import soc_pkg::*;

    localparam int         LOG_DEPTH  = 8;
    localparam int         NUM_PRESS  = 12;
    localparam int         NUM_REQ    = 4;
    localparam int         HOLD_CYC   = 20;         // Press and release length
    localparam int         WAIT_LIMIT = 200;
    localparam mem_data_t  WRITE_WORD = 32'h1234_5678;
    localparam port_byte_t FIRST_BYTE = 8'h21;      // Top byte of address 0
    localparam port_byte_t IDLE_BYTE  = 8'h81;      // Outer two LEDs

    logic       sdram_clk;
    logic       rst_n;
    logic       button;
    port_byte_t port_a;
    logic       ctrl_rst_n;
    logic       mem_init;
    mem_req_t   mem_req;
    logic       mem_done;
    mem_data_t  mem_rdata;
    int         req_count;
    mem_req_t   req_log [LOG_DEPTH];
    int         proto_errors;

    int checks;
    int errors;
    int timeouts;

    // ------------------------------------------------------------
    // Expected port_a and request count per press
    // ------------------------------------------------------------
    port_byte_t exp_byte [NUM_PRESS] = '{8'h30, 8'h55, 8'h55, 8'h51, 8'h59, 8'h54,
                                         8'h51, 8'h12, 8'h34, 8'h56, 8'h78, 8'h81};
    int exp_count [NUM_PRESS] = '{1, 1, 1, 2, 2, 2, 2, 4, 4, 4, 4, 4};  // Requests so far

    mem_req_t exp_req [NUM_REQ] = '{
        '{valid: 1'b1, rstrb: 1'b1, addr: 25'h0, wdata: 32'h0,      wmask: 4'h0},
        '{valid: 1'b1, rstrb: 1'b1, addr: 25'h4, wdata: 32'h0,      wmask: 4'h0},
        '{valid: 1'b1, rstrb: 1'b0, addr: 25'h8, wdata: WRITE_WORD, wmask: 4'hf},
        '{valid: 1'b1, rstrb: 1'b1, addr: 25'h8, wdata: 32'h0,      wmask: 4'h0}
    };

    sdram_test_soc #(
        .SYNC_STAGES(2),
        .WRITE_WORD (WRITE_WORD)
    ) i_sdram_test_soc (
        .sdram_clk (sdram_clk),
        .rst_n     (rst_n),
        .button    (button),
        .port_a    (port_a),
        .ctrl_rst_n(ctrl_rst_n),
        .mem_init  (mem_init),
        .mem_req   (mem_req),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata)
    );

    sdram_ctrl_model #(
        .LOG_DEPTH(LOG_DEPTH)
    ) i_sdram_ctrl_model (
        .sdram_clk   (sdram_clk),
        .ctrl_rst_n  (ctrl_rst_n),
        .mem_init    (mem_init),
        .mem_req     (mem_req),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .req_count   (req_count),
        .req_log     (req_log),
        .proto_errors(proto_errors)
    );

    initial begin
        sdram_clk = 1'b0;
        forever #5 sdram_clk = ~sdram_clk;
    end

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_bit(string name, logic got, logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_byte(string name, port_byte_t got, port_byte_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_count(string name, int got, int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_req(string name, mem_req_t got, mem_req_t exp);
        if (exp.wmask == '0) begin
            got.wdata = exp.wdata;      // Write data unused on reads
        end
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    // ------------------------------------------------------------
    // Waits sampled on the falling edge
    // ------------------------------------------------------------
    task automatic wait_port(port_byte_t exp);
        int n;
        n = 0;
        @(negedge sdram_clk);
        while (port_a !== exp && n < WAIT_LIMIT) begin
            @(negedge sdram_clk);
            n++;
        end
        if (port_a !== exp) begin
            timeouts++;
            $display("Timed out waiting for port_a to show 0x%h", exp);
        end
    endtask

    task automatic wait_requests(int count);
        int n;
        n = 0;
        while (req_count < count && n < WAIT_LIMIT) begin
            @(negedge sdram_clk);
            n++;
        end
        if (req_count < count) begin
            timeouts++;
            $display("Timed out waiting for request number %0d", count);
        end
    endtask

    task automatic wait_init();
        int n;
        n = 0;
        while (mem_init !== 1'b1 && n < WAIT_LIMIT) begin
            @(negedge sdram_clk);
            n++;
        end
        if (mem_init !== 1'b1) begin
            timeouts++;
            $display("Timed out waiting for controller init");
        end
    endtask

    // One press and release driven on the rising edge
    task automatic press_button();
        @(posedge sdram_clk);
        button <= 1'b0;
        repeat (HOLD_CYC) @(posedge sdram_clk);
        button <= 1'b1;
        repeat (HOLD_CYC) @(posedge sdram_clk);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin : main
        int next_req;           // First log entry not yet checked

        checks   = 0;
        errors   = 0;
        timeouts = 0;
        next_req = 0;
        rst_n    = 1'b0;
        button   = 1'b1;        // Released

        repeat (9) @(posedge sdram_clk);
        @(negedge sdram_clk);
        check_byte("port_a in reset", port_a, 8'h00);
        check_bit("mem_req.valid in reset", mem_req.valid, 1'b0);
        check_bit("ctrl_rst_n in reset", ctrl_rst_n, 1'b0);
        @(posedge sdram_clk);
        rst_n <= 1'b1;

        // Controller reset lasts two cycles after release
        @(posedge sdram_clk);
        @(negedge sdram_clk);
        check_bit("ctrl_rst_n one cycle after reset", ctrl_rst_n, 1'b0);
        @(posedge sdram_clk);
        @(negedge sdram_clk);
        check_bit("ctrl_rst_n two cycles after reset", ctrl_rst_n, 1'b1);

        wait_init();
        check_count("requests before init", req_count, 0);

        wait_requests(1);
        wait_port(FIRST_BYTE);
        check_byte("port_a after first read", port_a, FIRST_BYTE);

        for (int row = 0; row < NUM_PRESS; row++) begin
            press_button();
            wait_port(exp_byte[row]);
            check_byte($sformatf("port_a after press %0d", row + 1), port_a, exp_byte[row]);
            wait_requests(exp_count[row]);
            check_count($sformatf("req_count after press %0d", row + 1),
                        req_count, exp_count[row]);
            while (next_req < req_count && next_req < NUM_REQ) begin
                check_req($sformatf("mem_req %0d", next_req), req_log[next_req],
                          exp_req[next_req]);
                next_req++;
            end
        end

        // Idle holds its pattern
        press_button();
        press_button();
        @(negedge sdram_clk);
        check_byte("port_a in idle", port_a, IDLE_BYTE);
        check_count("req_count in idle", req_count, NUM_REQ);

        $display("Checks: %0d, check errors: %0d, timeouts: %0d, protocol errors: %0d",
                 checks, errors, timeouts, proto_errors);
        if (errors == 0 && timeouts == 0 && proto_errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Whole run limit
    initial begin
        repeat (20000) @(posedge sdram_clk);
        $display("Simulation did not finish within the cycle limit");
        $display("TEST FAILED");
        $finish;
    end

endmodule

/* sdram_test_soc.f */
hw/mem_pkg.sv
hw/soc_pkg.sv
hw/step_button.sv
hw/mem_access.sv
hw/byte_display.sv
hw/soc_sequencer.sv
hw/sdram_test_soc.sv
bench/sdram_ctrl_model.sv
bench/tb_sdram_test_soc.sv

/* Makefile */
# Verilator simulation of the SDRAM bring-up sequencer

VERILATOR ?= verilator
TOP       ?= tb_sdram_test_soc
FILELIST  ?= sdram_test_soc.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list targets and variables"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "TEST OK" $(LOG); then echo "PASS"; else echo "FAIL, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
